//--- dv/fb_display_checker.sv
/* framebuffer display checker
   concurrent assertions on the drawer handshake, write window and blanking */

`timescale 1ns/10ps
`default_nettype none

`include "fb_consts.svh"

module fb_display_checker (
    input wire logic              clk_pix,
    input wire logic              rst_n,
    input wire logic              draw_busy,
    input wire logic              draw_done,
    input wire logic              fb_we,
    input wire fb_pkg::coord_t    sy,
    input wire logic              dvi_de,
    input wire logic [`COLRW-1:0] dvi_red,
    input wire logic [`COLRW-1:0] dvi_green,
    input wire logic [`COLRW-1:0] dvi_blue
);
    import fb_pkg::*;

    a_done_single: assert property (@(posedge clk_pix) disable iff (!rst_n)
        draw_done |=> !draw_done)
        else $error("draw_done held for more than one cycle");

    // writes stay in vertical blanking, away from scanout
    a_we_in_blank: assert property (@(posedge clk_pix) disable iff (!rst_n)
        fb_we |-> (sy >= coord_t'(`V_RES)))
        else $error("framebuffer write outside vertical blanking");

    a_black_in_blank: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !dvi_de |-> ((dvi_red == '0) && (dvi_green == '0) && (dvi_blue == '0)))
        else $error("colour output not black while data enable is low");

    a_done_ends_busy: assert property (@(posedge clk_pix) disable iff (!rst_n)
        draw_done |-> (!draw_busy && $past(draw_busy)))
        else $error("draw_done without busy falling on the same cycle");

    a_busy_falls_at_done: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $fell(draw_busy) |-> draw_done)
        else $error("draw_busy fell without draw_done");

endmodule

bind fb_display_top fb_display_checker i_checker (
    .clk_pix(clk_pix),
    .rst_n(rst_n),
    .draw_busy(draw_busy),
    .draw_done(draw_done),
    .fb_we(fb_we),
    .sy(sy),
    .dvi_de(dvi_de),
    .dvi_red(dvi_red),
    .dvi_green(dvi_green),
    .dvi_blue(dvi_blue)
);

`default_nettype wire

//--- dv/fb_display_tb.sv
/* framebuffer display testbench
   random line requests checked against a frame model on every cycle */

`timescale 1ns/10ps
`default_nettype none

`include "fb_consts.svh"

module fb_display_tb;
    import fb_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int FRAME_CYCLES    = `H_FULL * `V_FULL;
    localparam int NUM_REQ         = 8;
    localparam int DONE_LIMIT      = 2 * FRAME_CYCLES;   // request to done
    localparam int WATCHDOG_CYCLES = (NUM_REQ + 4) * FRAME_CYCLES + 400;

    logic               clk_pix;
    logic               rst_n;
    logic               draw_req;
    coord_t             line_y;
    fb_colr_t           line_colr;
    logic               draw_busy;
    logic               draw_done;
    logic [`COLRW-1:0]  dvi_red;
    logic [`COLRW-1:0]  dvi_green;
    logic [`COLRW-1:0]  dvi_blue;
    logic               dvi_hsync;
    logic               dvi_vsync;
    logic               dvi_de;

    // frame model
    logic [`FB_PIXELS-1:0] fb_model = '0;
    int                    mx;              // raster position seen at the outputs
    int                    my;
    int                    pend_row;
    logic                  pend_colr;
    int                    req_count = 0;   // accepted requests
    int                    done_count = 0;
    logic [31:0]           rng;

    fb_display_top i_dut (
        .clk_pix,
        .rst_n,
        .draw_req,
        .line_y,
        .line_colr,
        .draw_busy,
        .draw_done,
        .dvi_red,
        .dvi_green,
        .dvi_blue,
        .dvi_hsync,
        .dvi_vsync,
        .dvi_de
    );

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_PERIOD / 2) clk_pix = ~clk_pix;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH time=%0t signal=%s expected=%0h actual=%0h",
                     $time, name, expected, actual);
            fail_run("output value differs from the model");
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk_pix);
    endtask

    // drives a one cycle pulse from one falling edge to the next
    task automatic send_request(input int row, input logic colr);
        draw_req  = 1'b1;
        line_y    = coord_t'(row);
        line_colr = fb_colr_t'(colr);
        @(negedge clk_pix);
        draw_req  = 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (draw_done !== 1'b1) begin
            if (waited >= DONE_LIMIT) begin
                fail_run("draw_done did not arrive within two frames of the request");
            end else begin
                @(negedge clk_pix);
                waited++;
            end
        end
    endtask

    // starts two pixels before (0,0) to match the scanout pipeline depth
    always @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            mx <= `H_FULL - 2;
            my <= `V_FULL - 1;
        end else if (mx == `H_FULL - 1) begin
            mx <= 0;
            my <= (my == `V_FULL - 1) ? 0 : my + 1;
        end else begin
            mx <= mx + 1;
        end
    end

    always @(negedge clk_pix) begin : compare_outputs
        logic       exp_hs;
        logic       exp_vs;
        logic       exp_de;
        logic       exp_pix;
        logic [7:0] exp_col;
        exp_hs  = (mx >= `H_FS) && (mx < `H_SE);
        exp_vs  = (my >= `V_FS) && (my < `V_SE);
        exp_de  = (mx < `H_RES) && (my < `V_RES);
        exp_pix = (mx < `FB_WIDTH) && (my < `FB_HEIGHT) && fb_model[my * `FB_WIDTH + mx];
        exp_col = exp_pix ? 8'hFF : 8'h00;
        check("dvi_hsync", 32'(exp_hs), 32'(dvi_hsync));
        check("dvi_vsync", 32'(exp_vs), 32'(dvi_vsync));
        check("dvi_de", 32'(exp_de), 32'(dvi_de));
        check("dvi_red", 32'(exp_col), 32'(dvi_red));
        check("dvi_green", 32'(exp_col), 32'(dvi_green));
        check("dvi_blue", 32'(exp_col), 32'(dvi_blue));
        if (!rst_n) begin
            check("draw_busy", 32'd0, 32'(draw_busy));
            check("draw_done", 32'd0, 32'(draw_done));
        end
        if (draw_done === 1'b1) begin
            if (req_count == done_count) begin
                fail_run("draw_done pulsed with no accepted request");
            end else begin
                for (int c = 0; c < `FB_WIDTH; c++) begin
                    fb_model[pend_row * `FB_WIDTH + c] = pend_colr;  // row lands in blanking
                end
                done_count++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run("watchdog expired before the tests finished");
    end

    initial begin : stimulus
        int   row;
        int   first_row;
        int   alt_row;
        logic colr;
        rst_n     = 1'b0;
        draw_req  = 1'b0;
        line_y    = '0;
        line_colr = '0;
        rng       = 32'd98243;
        first_row = 0;
        repeat (4) @(posedge clk_pix);
        @(negedge clk_pix);
        rst_n = 1'b1;
        @(negedge clk_pix);
        check("draw_busy", 32'd0, 32'(draw_busy));
        check("draw_done", 32'd0, 32'(draw_done));

        wait_cycles(FRAME_CYCLES);  // the cleared framebuffer gives a black frame

        for (int i = 0; i < NUM_REQ; i++) begin
            rng  = lcg_next(rng);
            row  = int'((rng >> 16) % 32'd12);
            rng  = lcg_next(rng);
            colr = rng[24];
            if (i == 0) begin
                colr      = 1'b1;
                first_row = row;
            end
            if (i == NUM_REQ - 1) begin
                row  = first_row;  // erase the first line
                colr = 1'b0;
            end
            pend_row  = row;
            pend_colr = colr;
            check("draw_busy", 32'd0, 32'(draw_busy));
            req_count++;
            send_request(row, colr);
            check("draw_busy", 32'd1, 32'(draw_busy));

            // a second request while busy must be dropped
            if (i % 2 == 1) begin
                rng = lcg_next(rng);
                wait_cycles(int'((rng >> 16) % 32'd8));
                check("draw_busy", 32'd1, 32'(draw_busy));
                alt_row = (row + 5) % `FB_HEIGHT;
                send_request(alt_row, ~colr);
            end

            wait_done();
            check("draw_busy", 32'd0, 32'(draw_busy));
            rng = lcg_next(rng);
            wait_cycles(int'((rng >> 16) % 32'd64) + 2);
        end

        wait_cycles(FRAME_CYCLES + 4);  // one full frame with the final image

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/fb_pkg.sv
rtl/display_timings.sv
rtl/bram_sdp.sv
rtl/fb_line_drawer.sv
rtl/fb_scanout.sv
rtl/fb_display_top.sv
dv/fb_display_checker.sv
dv/fb_display_tb.sv

//--- rtl/bram_sdp.sv
/* simple dual-port block RAM
   one write port and one registered read port on a single clock */

`timescale 1ns/10ps
`default_nettype none

module bram_sdp #(
    parameter int WIDTH = 8,     // bits per word
    parameter int DEPTH = 256    // number of words
) (
    input  wire logic                     clk_pix,
    input  wire logic                     we,
    input  wire logic [$clog2(DEPTH)-1:0] addr_write,
    input  wire logic [$clog2(DEPTH)-1:0] addr_read,
    input  wire logic [WIDTH-1:0]         data_in,
    output      logic [WIDTH-1:0]         data_out
);

    logic [WIDTH-1:0] memory [DEPTH];

    // start cleared, no image is loaded
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            memory[i] = '0;
        end
    end

    // write port
    always @(posedge clk_pix) begin
        if (we) begin
            memory[addr_write] <= data_in;
        end
    end

    // read port, data one cycle after the address
    // a write to the same address shows up on the following read
    always_ff @(posedge clk_pix) begin
        data_out <= memory[addr_read];
    end

endmodule

`default_nettype wire

//--- rtl/display_timings.sv
/* display timings
   raster counters with registered sync and data enable decode,
   every output refers to the same pixel */

`timescale 1ns/10ps
`default_nettype none

`include "fb_consts.svh"

module display_timings (
    input  wire logic   clk_pix,
    input  wire logic   rst_n,
    output fb_pkg::coord_t sx,      // horizontal position
    output fb_pkg::coord_t sy,      // vertical position
    output logic        hsync,
    output logic        vsync,
    output logic        de          // visible area
);
    import fb_pkg::*;

    coord_t sx_next;
    coord_t sy_next;
    logic   hs_next;
    logic   vs_next;
    logic   de_next;

    // next raster position
    always_comb begin
        sx_next = sx + coord_t'(1);
        sy_next = sy;
        if (sx == coord_t'(`H_FULL - 1)) begin
            sx_next = '0;  // end of line
            if (sy == coord_t'(`V_FULL - 1)) begin
                sy_next = '0;  // end of frame
            end else begin
                sy_next = sy + coord_t'(1);
            end
        end
    end

    // decode from the next position so the flops line up with sx and sy
    always_comb begin
        hs_next = (sx_next >= coord_t'(`H_FS)) && (sx_next < coord_t'(`H_SE));
        vs_next = (sy_next >= coord_t'(`V_FS)) && (sy_next < coord_t'(`V_SE));
        de_next = (sx_next < coord_t'(`H_RES)) && (sy_next < coord_t'(`V_RES));
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= !1'(`H_POL);  // (0,0) sits outside both sync pulses
            vsync <= !1'(`V_POL);
            de    <= 1'b1;         // (0,0) is visible
        end else begin
            sx    <= sx_next;
            sy    <= sy_next;
            hsync <= (hs_next == 1'(`H_POL));
            vsync <= (vs_next == 1'(`V_POL));
            de    <= de_next;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fb_consts.svh
/* framebuffer display constants
   screen timing, framebuffer geometry and bus widths */

`ifndef FB_CONSTS_SVH
`define FB_CONSTS_SVH

// horizontal timing in pixels
`define H_RES      32   // visible pixels per line
`define H_FS       34   // hsync start
`define H_SE       37   // hsync end
`define H_FULL     40   // total columns

// vertical timing in lines
`define V_RES      24   // visible lines
`define V_FS       25   // vsync start
`define V_SE       26   // vsync end
`define V_FULL     28   // total lines

// sync polarity, 1 is active high
`define H_POL      1
`define V_POL      1

// screen coordinate width
`define CORDW      6

// framebuffer in the top-left corner of the screen
`define FB_WIDTH   16
`define FB_HEIGHT  12
`define FB_PIXELS  192
`define FB_ADDRW   8
`define FB_DATAW   1    // one bit per pixel

// output colour channel width
`define COLRW      8

`endif

//--- rtl/fb_display_top.sv
/* framebuffer display top level
   timing generator, line drawer, framebuffer RAM and scanout */

`timescale 1ns/10ps
`default_nettype none

`include "fb_consts.svh"

module fb_display_top (
    input  wire logic             clk_pix,
    input  wire logic             rst_n,
    input  wire logic             draw_req,
    input  wire fb_pkg::coord_t   line_y,
    input  wire fb_pkg::fb_colr_t line_colr,
    output logic                  draw_busy,
    output logic                  draw_done,
    output logic [`COLRW-1:0]     dvi_red,
    output logic [`COLRW-1:0]     dvi_green,
    output logic [`COLRW-1:0]     dvi_blue,
    output logic                  dvi_hsync,
    output logic                  dvi_vsync,
    output logic                  dvi_de
);
    import fb_pkg::*;

    // raster position and timing
    coord_t sx;
    coord_t sy;
    logic   hsync;
    logic   vsync;
    logic   de;

    // framebuffer ports
    logic     fb_we;
    fb_addr_t fb_addr_write;
    fb_addr_t fb_addr_read;
    fb_colr_t fb_colr_write;
    fb_colr_t fb_colr_read;

    display_timings timings_inst (
        .clk_pix,
        .rst_n,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de
    );

    fb_line_drawer drawer_inst (
        .clk_pix,
        .rst_n,
        .sx,
        .sy,
        .draw_req,
        .line_y,
        .line_colr,
        .fb_we,
        .fb_addr_write,
        .fb_colr_write,
        .draw_busy,
        .draw_done
    );

    bram_sdp #(
        .WIDTH(`FB_DATAW),
        .DEPTH(`FB_PIXELS)
    ) fb_inst (
        .clk_pix,
        .we(fb_we),
        .addr_write(fb_addr_write),
        .addr_read(fb_addr_read),
        .data_in(fb_colr_write),
        .data_out(fb_colr_read)
    );

    fb_scanout scanout_inst (
        .clk_pix,
        .rst_n,
        .sx,
        .sy,
        .hsync,
        .vsync,
        .de,
        .fb_colr_read,
        .fb_addr_read,
        .dvi_red,
        .dvi_green,
        .dvi_blue,
        .dvi_hsync,
        .dvi_vsync,
        .dvi_de
    );

endmodule

`default_nettype wire

//--- rtl/fb_line_drawer.sv
/* framebuffer line drawer
   takes a line request, waits for vertical blanking and
   writes one full framebuffer row in a single burst */

`timescale 1ns/10ps
`default_nettype none

`include "fb_consts.svh"

module fb_line_drawer (
    input  wire logic            clk_pix,
    input  wire logic            rst_n,
    input  wire fb_pkg::coord_t  sx,
    input  wire fb_pkg::coord_t  sy,
    input  wire logic            draw_req,       // one cycle pulse
    input  wire fb_pkg::coord_t  line_y,         // row to paint
    input  wire fb_pkg::fb_colr_t line_colr,     // colour to paint
    output logic                 fb_we,
    output fb_pkg::fb_addr_t     fb_addr_write,
    output fb_pkg::fb_colr_t     fb_colr_write,
    output logic                 draw_busy,
    output logic                 draw_done
);
    import fb_pkg::*;

    localparam int COLW = $clog2(`FB_WIDTH);

    draw_state_t     state;
    logic [COLW-1:0] col;          // column within the row
    fb_addr_t        row_base;     // address of column 0 of the row
    fb_colr_t        colr_q;
    coord_t          y_clamped;
    logic            req_take;
    logic            blank_start;

    always_comb begin
        if (line_y >= coord_t'(`FB_HEIGHT)) begin
            y_clamped = coord_t'(`FB_HEIGHT - 1);  // stay inside the framebuffer
        end else begin
            y_clamped = line_y;
        end
    end

    assign req_take    = (state == DRAW_IDLE) && draw_req;
    assign blank_start = (sy == coord_t'(`V_RES)) && (sx == '0);  // first blanking cycle

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state <= DRAW_IDLE;
            col   <= '0;
        end else begin
            case (state)
                DRAW_IDLE: begin
                    col <= '0;
                    if (draw_req) state <= DRAW_WAIT;
                end
                DRAW_WAIT: begin
                    if (blank_start) state <= DRAW_LINE;
                end
                DRAW_LINE: begin
                    col <= col + 1'b1;
                    if (col == COLW'(`FB_WIDTH - 1)) state <= DRAW_DONE;
                end
                DRAW_DONE: state <= DRAW_IDLE;
                default:   state <= DRAW_IDLE;
            endcase
        end
    end

    // row and colour are held for the whole burst
    always_ff @(posedge clk_pix) begin
        if (req_take) begin
            row_base <= fb_addr_t'(y_clamped) * fb_addr_t'(`FB_WIDTH);
            colr_q   <= line_colr;
        end
    end

    always_comb begin
        fb_we         = (state == DRAW_LINE);
        fb_addr_write = row_base + fb_addr_t'(col);
        fb_colr_write = colr_q;
        draw_busy     = (state == DRAW_WAIT) || (state == DRAW_LINE);
        draw_done     = (state == DRAW_DONE);  // busy drops on the same cycle
    end

endmodule

`default_nettype wire

//--- rtl/fb_pkg.sv
/* framebuffer display types
   coordinate, address and pixel types plus the line drawer states */

`default_nettype none

`include "fb_consts.svh"

package fb_pkg;

    typedef logic [`CORDW-1:0]    coord_t;     // screen x or y
    typedef logic [`FB_ADDRW-1:0] fb_addr_t;   // framebuffer word address
    typedef logic [`FB_DATAW-1:0] fb_colr_t;   // framebuffer pixel

    // line drawer states
    typedef enum logic [1:0] {
        DRAW_IDLE,   // waiting for a request
        DRAW_WAIT,   // request taken, waiting for vertical blanking
        DRAW_LINE,   // streaming one row of writes
        DRAW_DONE    // one cycle completion
    } draw_state_t;

endpackage

`default_nettype wire

//--- rtl/fb_scanout.sv
/* framebuffer scanout
   raster read of the framebuffer window and registered
   colour, sync and data enable outputs for a DVI encoder */

`timescale 1ns/10ps
`default_nettype none

`include "fb_consts.svh"

module fb_scanout (
    input  wire logic             clk_pix,
    input  wire logic             rst_n,
    input  wire fb_pkg::coord_t   sx,
    input  wire fb_pkg::coord_t   sy,
    input  wire logic             hsync,
    input  wire logic             vsync,
    input  wire logic             de,
    input  wire fb_pkg::fb_colr_t fb_colr_read,    // RAM data, one cycle late
    output fb_pkg::fb_addr_t      fb_addr_read,
    output logic [`COLRW-1:0]     dvi_red,
    output logic [`COLRW-1:0]     dvi_green,
    output logic [`COLRW-1:0]     dvi_blue,
    output logic                  dvi_hsync,
    output logic                  dvi_vsync,
    output logic                  dvi_de
);
    import fb_pkg::*;

    logic fb_active;     // current pixel inside the framebuffer window
    logic frame_end;
    logic active_q;      // stage 1, aligned with RAM data
    logic hsync_q;
    logic vsync_q;
    logic de_q;
    logic pix_on;

    always_comb begin
        fb_active = (sx < coord_t'(`FB_WIDTH)) && (sy < coord_t'(`FB_HEIGHT));
        frame_end = (sx == coord_t'(`H_FULL - 1)) && (sy == coord_t'(`V_FULL - 1));
    end

    // read address is the raster index of the current pixel
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            fb_addr_read <= '0;
        end else if (frame_end) begin
            fb_addr_read <= '0;
        end else if (fb_active) begin
            fb_addr_read <= fb_addr_read + fb_addr_t'(1);
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            hsync_q  <= 1'b0;
            vsync_q  <= 1'b0;
            de_q     <= 1'b0;
        end else begin
            active_q <= fb_active;
            hsync_q  <= hsync;
            vsync_q  <= vsync;
            de_q     <= de;
        end
    end

    assign pix_on = active_q && (fb_colr_read != '0);  // black outside the window

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            dvi_red   <= '0;
            dvi_green <= '0;
            dvi_blue  <= '0;
            dvi_hsync <= 1'b0;
            dvi_vsync <= 1'b0;
            dvi_de    <= 1'b0;
        end else begin
            dvi_red   <= pix_on ? '1 : '0;  // white or black
            dvi_green <= pix_on ? '1 : '0;
            dvi_blue  <= pix_on ? '1 : '0;
            dvi_hsync <= hsync_q;
            dvi_vsync <= vsync_q;
            dvi_de    <= de_q;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the framebuffer display testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f files.f \
    --top-module fb_display_tb \
    -o fb_display_sim

# the log decides the result, not the exit status of the pipe
./obj_dir/fb_display_sim 2>&1 | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
